// ==== hw/vga_pkg.sv ====
/*
 * VGA package
 * Raster constants for 640x480, the colour set, the video bus struct
 * and the types used by the menu stage.
 */

`default_nettype none

package vga_pkg;

    // Visible area and full raster, in pixels and lines
    localparam logic [10:0] HOR_PIXELS = 11'd640;
    localparam logic [10:0] VER_PIXELS = 11'd480;
    localparam logic [10:0] HOR_TOTAL  = 11'd800;
    localparam logic [10:0] VER_TOTAL  = 11'd525;

    // Sync pulses are active high, START inclusive and STOP exclusive
    localparam logic [10:0] HOR_SYNC_START = 11'd656;
    localparam logic [10:0] HOR_SYNC_STOP  = 11'd752;
    localparam logic [10:0] VER_SYNC_START = 11'd490;
    localparam logic [10:0] VER_SYNC_STOP  = 11'd492;

    // Menu window sits in the top left corner of the screen
    localparam logic [10:0] MENU_WIDTH  = 11'd512;
    localparam logic [10:0] MENU_HEIGHT = 11'd384;

    // Clocks from the menu stage input to the ROM data
    localparam int MENU_DELAY = 2;

    // 12-bit RGB, 4 bits per channel
    localparam logic [11:0] BLANK_GREY      = 12'h888;
    localparam logic [11:0] BORDER_WHITE    = 12'hFFF;
    localparam logic [11:0] BACKGROUND_BLUE = 12'h004;
    localparam logic [11:0] BLACK           = 12'h000;

    typedef struct packed {
        logic [10:0] hcount;
        logic        hsync;
        logic        hblnk;
        logic [10:0] vcount;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

    // Image address in 8x8 pixel blocks
    typedef struct packed {
        logic [6:0] row_blk;
        logic [6:0] col_blk;
    } menu_addr_t;

    typedef enum logic {
        MODE_MENU,
        MODE_GAME
    } menu_mode_t;

endpackage

`default_nettype wire

// ==== hw/vga_timing.sv ====
/*
 * VGA timing generator
 * Counts pixels and lines of the 800x525 raster and decodes the
 * syncs and blanking for the 640x480 visible area.
 */

`default_nettype none

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_bus_t video
);

    import vga_pkg::*;

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        line_end;

    assign line_end = (video.hcount == HOR_TOTAL - 11'd1);

    // Next position in the raster, the line advances at each horizontal wrap
    always_comb begin
        if (line_end) begin
            hcount_nxt = '0;
            if (video.vcount == VER_TOTAL - 11'd1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = video.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = video.hcount + 11'd1;
            vcount_nxt = video.vcount;
        end
    end

    // The counts are the output registers themselves, so the flags are
    // decoded from the next position to stay aligned with them
    always_ff @(posedge clk) begin
        if (rst) begin
            video <= '0;
        end else begin
            video.hcount <= hcount_nxt;
            video.vcount <= vcount_nxt;
            video.hsync  <= (hcount_nxt >= HOR_SYNC_START) && (hcount_nxt < HOR_SYNC_STOP);
            video.vsync  <= (vcount_nxt >= VER_SYNC_START) && (vcount_nxt < VER_SYNC_STOP);
            video.hblnk  <= (hcount_nxt >= HOR_PIXELS);
            video.vblnk  <= (vcount_nxt >= VER_PIXELS);
            video.rgb    <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/draw_background.sv ====
/*
 * Background stage
 * Paints the visible area dark blue with a one-pixel white frame
 * around its edge and greys out the blanking intervals.
 */

`default_nettype none

module draw_background (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_bus_t video_in,
    output vga_pkg::vga_bus_t video_out
);

    import vga_pkg::*;

    logic [11:0] rgb_nxt;
    logic        on_border;

    assign on_border = (video_in.vcount == 11'd0) ||
                       (video_in.vcount == VER_PIXELS - 11'd1) ||
                       (video_in.hcount == 11'd0) ||
                       (video_in.hcount == HOR_PIXELS - 11'd1);

    always_comb begin
        if (video_in.hblnk || video_in.vblnk) begin
            rgb_nxt = BLANK_GREY;
        end else if (on_border) begin
            rgb_nxt = BORDER_WHITE;
        end else begin
            rgb_nxt = BACKGROUND_BLUE;
        end
    end

    // Timing passes through with one clock of latency
    always_ff @(posedge clk) begin
        if (rst) begin
            video_out <= '0;
        end else begin
            video_out     <= video_in;
            video_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/signal_delay.sv ====
/*
 * Signal delay line
 * Shifts a WIDTH-bit bus through CLK_DEL registers.
 */

`default_nettype none

module signal_delay #(
    parameter int WIDTH   = 1,
    parameter int CLK_DEL = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stages [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[CLK_DEL-1];

endmodule

`default_nettype wire

// ==== hw/menu_pattern_rom.sv ====
/*
 * Menu pattern ROM
 * Stands in for the menu image memory, one clock of read latency.
 * Each 8x8 block gets a colour computed from its row and column.
 */

`default_nettype none

module menu_pattern_rom (
    input  logic                clk,
    input  vga_pkg::menu_addr_t addr,
    output logic [11:0]         rgb
);

    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    // Red follows the column, green the row
    assign red   = addr.col_blk[3:0];
    assign green = addr.row_blk[3:0];

    // Blue checkerboard, set where the block parity is even
    assign blue = (^{addr.row_blk, addr.col_blk}) ? 4'h0 : 4'hF;

    always_ff @(posedge clk) begin
        rgb <= {red, green, blue};
    end

endmodule

`default_nettype wire

// ==== hw/draw_menu.sv ====
/*
 * Menu stage
 * Overlays the menu image on the 512x384 window while the game has
 * not started and blacks the window out once it has. The mode only
 * changes at the first pixel of a frame.
 */

`default_nettype none

module draw_menu (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_game,
    input  vga_pkg::vga_bus_t video_in,
    output vga_pkg::vga_bus_t video_out
);

    import vga_pkg::*;

    menu_addr_t  pixel_addr;
    logic [11:0] rom_rgb;
    vga_bus_t    video_dly;
    menu_mode_t  mode;
    menu_mode_t  mode_nxt;
    logic        frame_start;
    logic        in_window;
    logic [11:0] rgb_nxt;

    // Image address in 8x8 blocks, ROM data follows one clock later
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr.row_blk <= 7'(video_in.vcount >> 3);
            pixel_addr.col_blk <= 7'(video_in.hcount >> 3);
        end
    end

    menu_pattern_rom u_menu_pattern_rom (
        .clk,
        .addr (pixel_addr),
        .rgb  (rom_rgb)
    );

    // Timing copy that lines up with the ROM data
    signal_delay #(
        .WIDTH   ($bits(vga_bus_t)),
        .CLK_DEL (MENU_DELAY)
    ) u_signal_delay (
        .clk,
        .rst,
        .din  (video_in),
        .dout (video_dly)
    );

    assign frame_start = (video_dly.hcount == 11'd0) && (video_dly.vcount == 11'd0);

    // start_game is taken in only at the top of a frame and already
    // applies to that first pixel
    always_comb begin
        if (frame_start) begin
            mode_nxt = start_game ? MODE_GAME : MODE_MENU;
        end else begin
            mode_nxt = mode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_nxt;
        end
    end

    assign in_window = (video_dly.hcount < MENU_WIDTH) && (video_dly.vcount < MENU_HEIGHT);

    always_comb begin
        if (video_dly.hblnk || video_dly.vblnk) begin
            rgb_nxt = BLANK_GREY;
        end else if (in_window) begin
            rgb_nxt = (mode_nxt == MODE_MENU) ? rom_rgb : BLACK;
        end else begin
            rgb_nxt = video_dly.rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            video_out <= '0;
        end else begin
            video_out     <= video_dly;
            video_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/menu_display.sv ====
/*
 * Menu display top level
 * Chains the raster generator, the background stage and the menu
 * stage into one 640x480 video pipeline.
 */

`default_nettype none

module menu_display (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_game,
    output vga_pkg::vga_bus_t video
);

    import vga_pkg::*;

    vga_bus_t timing_bus;
    vga_bus_t background_bus;

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .video (timing_bus)
    );

    draw_background u_draw_background (
        .clk,
        .rst,
        .video_in  (timing_bus),
        .video_out (background_bus)
    );

    // Output lags the raster counters by four clocks in total
    draw_menu u_draw_menu (
        .clk,
        .rst,
        .start_game,
        .video_in  (background_bus),
        .video_out (video)
    );

endmodule

`default_nettype wire

// ==== tests/menu_display_asserts.sv ====
/*
 * Menu stage assertions
 * Blanking colour, frame-aligned mode changes and the pixel count range
 * on the output of the menu stage.
 */

`default_nettype none

module menu_display_asserts (
    input logic                clk,
    input logic                rst,
    input vga_pkg::vga_bus_t   video_out,
    input vga_pkg::menu_mode_t mode
);

    import vga_pkg::*;

    int failures = 0;

    blank_is_grey: assert property (@(posedge clk) disable iff (rst)
        (video_out.hblnk || video_out.vblnk) |-> (video_out.rgb == BLANK_GREY))
    else begin
        failures++;
        $error("Blanking pixel is not grey");
    end

    // A new mode shows up together with the first pixel of a frame on the output
    mode_at_frame_start: assert property (@(posedge clk) disable iff (rst)
        (mode != $past(mode)) |-> ((video_out.hcount == 11'd0) && (video_out.vcount == 11'd0)))
    else begin
        failures++;
        $error("Menu mode changed away from the first pixel of a frame");
    end

    hcount_in_range: assert property (@(posedge clk) disable iff (rst)
        video_out.hcount < HOR_TOTAL)
    else begin
        failures++;
        $error("Pixel count ran past the end of the line");
    end

endmodule

bind draw_menu menu_display_asserts u_menu_asserts (
    .clk,
    .rst,
    .video_out,
    .mode
);

`default_nettype wire

// ==== tests/menu_display_tb.sv ====
/*
 * Menu display testbench
 * Picks start_game from an LFSR once per frame and checks every output
 * pixel against a model of the raster, background and menu rules.
 */

`default_nettype none

module menu_display_tb;

    import vga_pkg::*;

    localparam int FRAME_LIMIT = int'(VER_TOTAL) * int'(HOR_TOTAL) + 10;

    logic        clk;
    logic        rst;
    logic        start_game;
    logic        next_start;
    logic        exp_game;
    logic [7:0]  lfsr_state;
    logic [10:0] exp_h;
    logic [10:0] exp_v;
    vga_bus_t    video;
    int          mismatch_count;
    int          timeout_count;
    int          assert_count;
    int          cycles;
    int          frames;

    menu_display menu_display_inst (
        .clk,
        .rst,
        .start_game,
        .video
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR on x^8 + x^6 + x^5 + x^4 + 1 with the new bit entering at the bottom
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic take_random_bit(output logic value);
        lfsr_state = lfsr_next(lfsr_state);
        value = lfsr_state[0];
    endtask

    function automatic vga_bus_t expected_pixel(input logic [10:0] h, input logic [10:0] v,
                                                input logic game);
        vga_bus_t   px;
        logic [6:0] col;
        logic [6:0] row;
        logic [3:0] blue;
        col  = h[9:3];
        row  = v[9:3];
        // Blue is lit on blocks whose address bits have even parity
        blue = ($countones({row, col}) % 2 == 0) ? 4'hF : 4'h0;
        px.hcount = h;
        px.vcount = v;
        px.hsync  = (h >= HOR_SYNC_START) && (h < HOR_SYNC_STOP);
        px.vsync  = (v >= VER_SYNC_START) && (v < VER_SYNC_STOP);
        px.hblnk  = (h >= HOR_PIXELS);
        px.vblnk  = (v >= VER_PIXELS);
        if (px.hblnk || px.vblnk) begin
            px.rgb = BLANK_GREY;
        end else if ((h < MENU_WIDTH) && (v < MENU_HEIGHT)) begin
            px.rgb = game ? BLACK : {col[3:0], row[3:0], blue};
        end else if ((h == 11'd0) || (v == 11'd0) || (h == HOR_PIXELS - 11'd1) ||
                     (v == VER_PIXELS - 11'd1)) begin
            px.rgb = BORDER_WHITE;
        end else begin
            px.rgb = BACKGROUND_BLUE;
        end
        return px;
    endfunction

    task automatic check_rgb(input string name, input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [10:0] got, input logic [10:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_pixel(input vga_bus_t exp);
        check_count("hcount", video.hcount, exp.hcount);
        check_count("vcount", video.vcount, exp.vcount);
        check_flag("hsync", video.hsync, exp.hsync);
        check_flag("vsync", video.vsync, exp.vsync);
        check_flag("hblnk", video.hblnk, exp.hblnk);
        check_flag("vblnk", video.vblnk, exp.vblnk);
        check_rgb("rgb", video.rgb, exp.rgb);
    endtask

    // Advances one clock and lets start_game move only in the vertical blanking
    task automatic run_cycle();
        logic drive;
        drive = (video.vcount >= 11'd500) && (video.vcount <= 11'd520);
        if ((video.vcount == 11'd500) && (video.hcount == 11'd0)) begin
            take_random_bit(next_start);
        end
        @(posedge clk);
        if (drive) begin
            start_game <= next_start;
        end
        @(negedge clk);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        lfsr_state     = 8'd95;
        mismatch_count = 0;
        timeout_count  = 0;
        take_random_bit(next_start);
        start_game = next_start;
        exp_game   = next_start;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_pixel('0);
        end

        // Pixel 0,0 repeats while the pipeline fills and each copy must already be drawn right
        cycles = 0;
        while (!((video.hcount == 11'd1) && (video.vcount == 11'd0)) && (cycles < 500)) begin
            run_cycle();
            cycles++;
            if ((video.hcount == 11'd0) && (video.vcount == 11'd0)) begin
                exp_game = start_game;
                check_pixel(expected_pixel(11'd0, 11'd0, exp_game));
            end
        end
        if (cycles >= 500) begin
            $display("Timeout: the first frame did not start within 500 clocks of reset");
            timeout_count++;
        end

        exp_h  = 11'd1;
        exp_v  = 11'd0;
        frames = 0;
        while ((timeout_count == 0) && (frames < 4)) begin
            cycles = 0;
            do begin
                check_pixel(expected_pixel(exp_h, exp_v, exp_game));
                if (exp_h == HOR_TOTAL - 11'd1) begin
                    exp_h = 11'd0;
                    exp_v = (exp_v == VER_TOTAL - 11'd1) ? 11'd0 : exp_v + 11'd1;
                end else begin
                    exp_h = exp_h + 11'd1;
                end
                run_cycle();
                cycles++;
            end while (!((video.hcount == 11'd0) && (video.vcount == 11'd0)) &&
                       (cycles < FRAME_LIMIT));
            if ((video.hcount == 11'd0) && (video.vcount == 11'd0)) begin
                exp_game = start_game;
                frames++;
            end else begin
                $display("Timeout: no new frame started within %0d clocks", FRAME_LIMIT);
                timeout_count++;
            end
        end

        assert_count = menu_display_inst.u_draw_menu.u_menu_asserts.failures;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, assert_count);
        if ((mismatch_count == 0) && (timeout_count == 0) && (assert_count == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== menu_display.f ====
hw/vga_pkg.sv
hw/vga_timing.sv
hw/draw_background.sv
hw/signal_delay.sv
hw/menu_pattern_rom.sv
hw/draw_menu.sv
hw/menu_display.sv
tests/menu_display_asserts.sv
tests/menu_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the menu display testbench with Verilator, runs it and checks the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module menu_display_tb \
    -f menu_display.f -o menu_display_sim || exit 1
sim_output=$(./obj_dir/menu_display_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "Verification passed" && echo "PASS" || { echo "FAIL"; exit 1; }
